//--- source/mips16_macros.svh
// Widths and instruction-field positions for the 16-bit five-stage processor.
// Include this file wherever a width or a field position is needed.
`ifndef MIPS16_MACROS_SVH
`define MIPS16_MACROS_SVH

// data, address and instruction words are all this wide.
`define MIPS16_WORD_W 16
`define MIPS16_OP_W 5       // opcode field width.
`define MIPS16_REG_W 3      // register index width.

// general register count.
`define MIPS16_NUM_REGS 8

// low bit of each instruction field.
`define MIPS16_OP_LSB 11    // opcode in 15..11.
`define MIPS16_R1_LSB 8     // r1 in 10..8, imm8 below it.
`define MIPS16_R2_LSB 4     // r2 in 6..4, imm4 below it.
`define MIPS16_R3_LSB 0     // r3 in 2..0.

`endif

//--- source/mips16_pkg.sv
// Shared types of the processor, with the opcode set and the helpers that
// classify opcodes by the registers they read and write.
// Compile after the macro header and before every RTL module.
`include "mips16_macros.svh"

package mips16_pkg;

  typedef logic [`MIPS16_WORD_W-1:0] word_t;   // data, address or instruction.
  typedef logic [`MIPS16_REG_W-1:0] reg_idx_t;  // general register index.

  typedef enum logic [`MIPS16_OP_W-1:0] {
    OP_NOP    = 5'd0,
    OP_HALT   = 5'd1,
    OP_STORE  = 5'd2,
    OP_LDIH   = 5'd3,
    OP_ADD    = 5'd4,
    OP_ADDI   = 5'd5,
    OP_SUB    = 5'd7,
    OP_SUBI   = 5'd8,
    OP_CMP    = 5'd10,
    OP_AND    = 5'd11,
    OP_OR     = 5'd12,
    OP_XOR    = 5'd13,
    OP_SLL    = 5'd14,
    OP_SRL    = 5'd15,
    OP_SLA    = 5'd16,
    OP_SRA    = 5'd17,
    OP_JUMP   = 5'd18,
    OP_JMPR   = 5'd19,
    OP_BZ     = 5'd20,
    OP_BNZ    = 5'd21,
    OP_BN     = 5'd22,
    OP_BNN    = 5'd23,
    OP_LOAD   = 5'd26,
    OP_BUBBLE = 5'd31     // load-use filler, acts as NOP.
  } opcode_t;

  // what rides down the pipe after decode.
  typedef struct packed {
    opcode_t  op;
    reg_idx_t rd;         // destination, always the r1 field.
  } stage_ir_t;

  // result goes back into the register file.
  function automatic logic writes_reg(input opcode_t op);
    case (op)
      OP_LOAD, OP_LDIH, OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_AND, OP_OR, OP_XOR,
      OP_SLL, OP_SRL, OP_SLA, OP_SRA: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // r1 is a source operand.
  function automatic logic reads_r1(input opcode_t op);
    case (op)
      OP_STORE, OP_LDIH, OP_ADDI, OP_SUBI, OP_JMPR,
      OP_BZ, OP_BNZ, OP_BN, OP_BNN: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // r2 is a source operand.
  function automatic logic reads_r2(input opcode_t op);
    case (op)
      OP_LOAD, OP_STORE, OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_OR, OP_XOR,
      OP_SLL, OP_SRL, OP_SLA, OP_SRA: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // r3 is a source operand, three-register forms only.
  function automatic logic reads_r3(input opcode_t op);
    case (op)
      OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_OR, OP_XOR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // zf and nf follow this result.
  function automatic logic sets_flags(input opcode_t op);
    case (op)
      OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_CMP, OP_AND, OP_OR, OP_XOR,
      OP_SLL, OP_SRL, OP_SLA, OP_SRA: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

//--- source/mips16_run_ctrl.sv
// Run/idle control. The processor runs once start is pressed with power
// enabled, and stops on power loss or when HALT reaches write-back.
module mips16_run_ctrl (
  input  logic                 clk,
  input  logic                 i_reset,
  input  logic                 i_start,     // start button level.
  input  logic                 i_enable,    // power enable level.
  input  mips16_pkg::stage_ir_t i_wb_ir,
  output logic                 o_running
);
  import mips16_pkg::*;

  typedef enum logic {ST_IDLE, ST_EXEC} state_t;

  state_t state;

  always_ff @(posedge clk)
  begin
    if (i_reset)
      state <= ST_IDLE;
    else if (state == ST_IDLE)
    begin
      if (i_enable && i_start)
        state <= ST_EXEC;
    end
    else if (!i_enable || (i_wb_ir.op == OP_HALT))
      state <= ST_IDLE;                            // power lost or halted.
  end

  assign o_running = (state == ST_EXEC);           // gates every pipeline register.

endmodule

//--- source/mips16_fetch.sv
// Fetch stage. Holds the pc and the fetch/decode instruction register,
// inserts a bubble when the fetched word needs a register that the LOAD
// in decode has not yet read, and takes branch targets from the memory stage.
`include "mips16_macros.svh"

module mips16_fetch (
  input  logic              clk,
  input  logic              i_reset,
  input  logic              i_running,
  input  mips16_pkg::word_t i_instr,          // word at o_instr_addr, same cycle.
  input  logic              i_branch_taken,
  input  mips16_pkg::word_t i_branch_target,
  output mips16_pkg::word_t o_instr_addr,
  output mips16_pkg::word_t o_id_ir
);
  import mips16_pkg::*;

  word_t    pc;
  opcode_t  if_op, id_op;
  reg_idx_t id_rd;
  logic     load_use;
  logic     redirect_q;                          // branch seen during a stall.
  word_t    redirect_pc;

  assign if_op = opcode_t'(i_instr[`MIPS16_OP_LSB +: `MIPS16_OP_W]);
  assign id_op = opcode_t'(o_id_ir[`MIPS16_OP_LSB +: `MIPS16_OP_W]);
  assign id_rd = o_id_ir[`MIPS16_R1_LSB +: `MIPS16_REG_W];

  // the load result is not forwardable until it reaches memory.
  assign load_use = (id_op == OP_LOAD)
    && ((reads_r1(if_op) && (i_instr[`MIPS16_R1_LSB +: `MIPS16_REG_W] == id_rd))
     || (reads_r2(if_op) && (i_instr[`MIPS16_R2_LSB +: `MIPS16_REG_W] == id_rd))
     || (reads_r3(if_op) && (i_instr[`MIPS16_R3_LSB +: `MIPS16_REG_W] == id_rd)));

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      pc         <= '0;
      o_id_ir    <= '0;                          // NOP.
      redirect_q <= 1'b0;
    end
    else if (i_running)
    begin
      if (load_use)
      begin
        o_id_ir    <= {OP_BUBBLE, o_id_ir[`MIPS16_OP_LSB-1:0]}; // pc holds.
        redirect_q <= i_branch_taken;            // keep a redirect the stall would lose.
      end
      else
      begin
        o_id_ir    <= i_instr;
        redirect_q <= 1'b0;
        if (redirect_q)
          pc <= redirect_pc;
        else if (i_branch_taken)
          pc <= i_branch_target;
        else
          pc <= pc + 1'b1;
      end
    end
  end

  // saved target, only meaningful while redirect_q is set.
  always_ff @(posedge clk)
  begin
    if (i_running && load_use && i_branch_taken)
      redirect_pc <= i_branch_target;
  end

  assign o_instr_addr = pc;

endmodule

//--- source/mips16_decode.sv
// Decode stage. Owns the general registers, written from write-back, and
// registers operands A and B, the store data and the execute-stage
// instruction. Each source register takes the youngest in-flight result:
// execute, then memory, then write-back, then the register file.
`include "mips16_macros.svh"

module mips16_decode (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_running,
  input  mips16_pkg::word_t     i_id_ir,
  input  mips16_pkg::stage_ir_t i_ex_ir,
  input  mips16_pkg::stage_ir_t i_mem_ir,
  input  mips16_pkg::stage_ir_t i_wb_ir,
  input  mips16_pkg::word_t     i_alu_out,     // execute result, this cycle.
  input  mips16_pkg::word_t     i_mem_result,  // memory-stage alu result.
  input  mips16_pkg::word_t     i_d_rdata,     // load data, this cycle.
  input  mips16_pkg::word_t     i_wb_result,
  output mips16_pkg::stage_ir_t o_ex_ir,
  output mips16_pkg::word_t     o_reg_a,
  output mips16_pkg::word_t     o_reg_b,
  output mips16_pkg::word_t     o_store_data
);
  import mips16_pkg::*;

  word_t    gr [`MIPS16_NUM_REGS];                // general registers.
  word_t    fwd_gr [`MIPS16_NUM_REGS];            // register view after forwarding.
  opcode_t  id_op;
  reg_idx_t id_r1, id_r2, id_r3;
  logic [`MIPS16_R1_LSB-1:0] imm8;
  logic [`MIPS16_R2_LSB-1:0] imm4;
  logic     ex_fwd, mem_fwd, wb_fwd;
  word_t    mem_fwd_val;

  assign id_op = opcode_t'(i_id_ir[`MIPS16_OP_LSB +: `MIPS16_OP_W]);
  assign id_r1 = i_id_ir[`MIPS16_R1_LSB +: `MIPS16_REG_W];
  assign id_r2 = i_id_ir[`MIPS16_R2_LSB +: `MIPS16_REG_W];
  assign id_r3 = i_id_ir[`MIPS16_R3_LSB +: `MIPS16_REG_W];
  assign imm8  = i_id_ir[`MIPS16_R1_LSB-1:0];
  assign imm4  = i_id_ir[`MIPS16_R2_LSB-1:0];

  // a LOAD in execute only has its address, the stall covers that case.
  assign ex_fwd      = writes_reg(i_ex_ir.op) && (i_ex_ir.op != OP_LOAD);
  assign mem_fwd     = writes_reg(i_mem_ir.op);
  assign mem_fwd_val = (i_mem_ir.op == OP_LOAD) ? i_d_rdata : i_mem_result;
  assign wb_fwd      = writes_reg(i_wb_ir.op);   // written on this same edge.

  always_comb
  begin
    for (int i = 0; i < `MIPS16_NUM_REGS; i++)
    begin
      if (ex_fwd && (i_ex_ir.rd == reg_idx_t'(i)))
        fwd_gr[i] = i_alu_out;
      else if (mem_fwd && (i_mem_ir.rd == reg_idx_t'(i)))
        fwd_gr[i] = mem_fwd_val;
      else if (wb_fwd && (i_wb_ir.rd == reg_idx_t'(i)))
        fwd_gr[i] = i_wb_result;
      else
        fwd_gr[i] = gr[i];
    end
  end

  // write-back port.
  always_ff @(posedge clk)
  begin
    if (i_running && wb_fwd)
      gr[i_wb_ir.rd] <= i_wb_result;
  end

  always_ff @(posedge clk)
  begin
    if (i_reset)
      o_ex_ir <= '0;
    else if (i_running)
      o_ex_ir <= '{op: id_op, rd: id_r1};
  end

  // operands, unused ones keep their old value.
  always_ff @(posedge clk)
  begin
    if (i_running)
    begin
      if (reads_r2(id_op))
        o_reg_a <= fwd_gr[id_r2];                // loads, stores, alu and shifts.
      else if (reads_r1(id_op))
        o_reg_a <= fwd_gr[id_r1];                // immediates, jmpr and branches.

      if (reads_r3(id_op))
        o_reg_b <= fwd_gr[id_r3];
      else
      begin
        case (id_op)
          OP_LOAD, OP_STORE, OP_SLL, OP_SRL, OP_SLA, OP_SRA:
            o_reg_b <= word_t'(imm4);            // offset or shift count.
          OP_ADDI, OP_SUBI, OP_JUMP, OP_JMPR, OP_BZ, OP_BNZ, OP_BN, OP_BNN:
            o_reg_b <= word_t'(imm8);
          OP_LDIH:
            o_reg_b <= {imm8, {`MIPS16_R1_LSB{1'b0}}}; // upper byte.
          default: ;
        endcase
      end

      if (id_op == OP_STORE)
        o_store_data <= fwd_gr[id_r1];
    end
  end

endmodule

//--- source/mips16_alu.sv
// Combinational ALU of the execute stage. Also forms memory addresses and
// jump or branch targets, so the memory stage gets one result word.
module mips16_alu (
  input  mips16_pkg::opcode_t i_op,
  input  mips16_pkg::word_t   i_a,
  input  mips16_pkg::word_t   i_b,
  output mips16_pkg::word_t   o_result
);
  import mips16_pkg::*;

  always_comb
  begin
    case (i_op)
      // sums, including addresses and relative targets.
      OP_ADD, OP_ADDI, OP_LDIH, OP_LOAD, OP_STORE,
      OP_JMPR, OP_BZ, OP_BNZ, OP_BN, OP_BNN:
        o_result = i_a + i_b;
      OP_SUB, OP_SUBI, OP_CMP:
        o_result = i_a - i_b;                    // cmp keeps only the flags.
      OP_AND:
        o_result = i_a & i_b;
      OP_OR:
        o_result = i_a | i_b;
      OP_XOR:
        o_result = i_a ^ i_b;
      OP_SLL, OP_SLA:
        o_result = i_a << i_b[3:0];              // sla is the same as sll.
      OP_SRL:
        o_result = i_a >> i_b[3:0];
      OP_SRA:
        o_result = word_t'($signed(i_a) >>> i_b[3:0]); // sign fills.
      OP_JUMP:
        o_result = i_b;                          // absolute imm8 target.
      default:
        o_result = '0;                           // nop, halt, bubble.
    endcase
  end

endmodule

//--- source/mips16_execute.sv
// Execute stage. Runs the ALU, registers its result, the store data and the
// instruction into the memory stage, and keeps the zero and negative flags.
// The memory-stage side drives the data-memory port and the branch decision.
`include "mips16_macros.svh"

module mips16_execute (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_running,
  input  mips16_pkg::stage_ir_t i_ex_ir,
  input  mips16_pkg::word_t     i_reg_a,
  input  mips16_pkg::word_t     i_reg_b,
  input  mips16_pkg::word_t     i_store_data,
  output mips16_pkg::word_t     o_alu_out,
  output mips16_pkg::word_t     o_mem_result,  // also the branch target.
  output mips16_pkg::stage_ir_t o_mem_ir,
  output logic                  o_branch_taken,
  output mips16_pkg::word_t     o_d_addr,
  output mips16_pkg::word_t     o_d_wdata,
  output logic                  o_d_we
);
  import mips16_pkg::*;

  logic zf, nf;

  mips16_alu u_alu (
    .i_op     (i_ex_ir.op),
    .i_a      (i_reg_a),
    .i_b      (i_reg_b),
    .o_result (o_alu_out)
  );

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_mem_ir <= '0;
      zf       <= 1'b0;
      nf       <= 1'b0;
    end
    else if (i_running)
    begin
      o_mem_ir <= i_ex_ir;
      if (sets_flags(i_ex_ir.op))                // address sums leave flags alone.
      begin
        zf <= (o_alu_out == '0);
        nf <= o_alu_out[`MIPS16_WORD_W-1];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_running)
    begin
      o_mem_result <= o_alu_out;
      if (i_ex_ir.op == OP_STORE)
        o_d_wdata <= i_store_data;
    end
  end

  // flags here belong to the last setter ahead of the branch.
  always_comb
  begin
    case (o_mem_ir.op)
      OP_JUMP, OP_JMPR: o_branch_taken = 1'b1;
      OP_BZ:            o_branch_taken = zf;
      OP_BNZ:           o_branch_taken = !zf;
      OP_BN:            o_branch_taken = nf;
      OP_BNN:           o_branch_taken = !nf;
      default:          o_branch_taken = 1'b0;
    endcase
  end

  assign o_d_addr = o_mem_result;
  assign o_d_we   = i_running && (o_mem_ir.op == OP_STORE); // one strobe per store.

endmodule

//--- source/mips16_memory.sv
// Memory stage. Picks the load data or the ALU result for write-back and
// passes the instruction on; other instructions leave the result unchanged.
module mips16_memory (
  input  logic                  clk,
  input  logic                  i_reset,
  input  logic                  i_running,
  input  mips16_pkg::stage_ir_t i_mem_ir,
  input  mips16_pkg::word_t     i_mem_result,
  input  mips16_pkg::word_t     i_d_rdata,     // read the same cycle as the address.
  output mips16_pkg::stage_ir_t o_wb_ir,
  output mips16_pkg::word_t     o_wb_result
);
  import mips16_pkg::*;

  always_ff @(posedge clk)
  begin
    if (i_reset)
      o_wb_ir <= '0;
    else if (i_running)
      o_wb_ir <= i_mem_ir;
  end

  always_ff @(posedge clk)
  begin
    if (i_running)
    begin
      if (i_mem_ir.op == OP_LOAD)
        o_wb_result <= i_d_rdata;
      else if (writes_reg(i_mem_ir.op))
        o_wb_result <= i_mem_result;
    end
  end

endmodule

//--- source/mips16_top.sv
// Top level of the five-stage processor. Connects the stages to each other
// and to the separate instruction and data memories, both read combinationally.
module mips16_top (
  input  logic              clk,
  input  logic              i_reset,
  input  logic              i_start,
  input  logic              i_enable,
  input  mips16_pkg::word_t i_instr,
  input  mips16_pkg::word_t i_d_rdata,
  output mips16_pkg::word_t o_instr_addr,
  output mips16_pkg::word_t o_d_addr,
  output mips16_pkg::word_t o_d_wdata,
  output logic              o_d_we,
  output logic              o_running
);
  import mips16_pkg::*;

  word_t     id_ir;
  stage_ir_t ex_ir, mem_ir, wb_ir;
  word_t     reg_a, reg_b, store_data;
  word_t     alu_out, mem_result, wb_result;
  logic      branch_taken;

  mips16_run_ctrl u_run_ctrl (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_start   (i_start),
    .i_enable  (i_enable),
    .i_wb_ir   (wb_ir),
    .o_running (o_running)
  );

  mips16_fetch u_fetch (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_running       (o_running),
    .i_instr         (i_instr),
    .i_branch_taken  (branch_taken),
    .i_branch_target (mem_result),
    .o_instr_addr    (o_instr_addr),
    .o_id_ir         (id_ir)
  );

  mips16_decode u_decode (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_running    (o_running),
    .i_id_ir      (id_ir),
    .i_ex_ir      (ex_ir),
    .i_mem_ir     (mem_ir),
    .i_wb_ir      (wb_ir),
    .i_alu_out    (alu_out),
    .i_mem_result (mem_result),
    .i_d_rdata    (i_d_rdata),
    .i_wb_result  (wb_result),
    .o_ex_ir      (ex_ir),
    .o_reg_a      (reg_a),
    .o_reg_b      (reg_b),
    .o_store_data (store_data)
  );

  mips16_execute u_execute (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_running      (o_running),
    .i_ex_ir        (ex_ir),
    .i_reg_a        (reg_a),
    .i_reg_b        (reg_b),
    .i_store_data   (store_data),
    .o_alu_out      (alu_out),
    .o_mem_result   (mem_result),
    .o_mem_ir       (mem_ir),
    .o_branch_taken (branch_taken),
    .o_d_addr       (o_d_addr),
    .o_d_wdata      (o_d_wdata),
    .o_d_we         (o_d_we)
  );

  mips16_memory u_memory (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_running    (o_running),
    .i_mem_ir     (mem_ir),
    .i_mem_result (mem_result),
    .i_d_rdata    (i_d_rdata),
    .o_wb_ir      (wb_ir),
    .o_wb_result  (wb_result)
  );

endmodule

//--- verif/mips16_tb.sv
// Testbench for the five-stage processor. Runs a table of small programs
// against combinational instruction and data memory models, logs every store
// and compares the log with stores predicted from the instruction semantics.
// Also checks the idle behaviour and the power-enable drop.
module mips16_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mips16_pkg::*;

  localparam int NT   = 3;                      // tests in the table.
  localparam int PMAX = 80;                     // program words per test.
  localparam int SMAX = 32;                     // expected stores per test.

  logic  clk;
  logic  i_reset, i_start, i_enable;
  word_t i_instr, i_d_rdata;
  word_t o_instr_addr, o_d_addr, o_d_wdata;
  logic  o_d_we, o_running;

  word_t imem [256];
  word_t dmem [256];
  word_t log_addr [$];                          // every store seen, in order.
  word_t log_val [$];

  string names [NT];
  word_t prog [NT][PMAX];
  int    plen [NT];
  word_t pre [NT][16];                          // data preload, words 0..15.
  word_t exp_a [NT][SMAX];
  word_t exp_v [NT][SMAX];
  int    exp_n [NT];
  int    cur;                                   // test being built or run.
  string cur_name;
  int    cycles = 0;
  int    limit = 0;
  logic [31:0] seed = 32'h56a98ad8;

  mips16_top mips16_top_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_start      (i_start),
    .i_enable     (i_enable),
    .i_instr      (i_instr),
    .i_d_rdata    (i_d_rdata),
    .o_instr_addr (o_instr_addr),
    .o_d_addr     (o_d_addr),
    .o_d_wdata    (o_d_wdata),
    .o_d_we       (o_d_we),
    .o_running    (o_running)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;                        // 100 ns period.

  assign i_instr = imem[o_instr_addr[7:0]];
  // registers come up unknown, so an unknown address reads as zero.
  assign i_d_rdata = $isunknown(o_d_addr) ? '0 : dmem[o_d_addr[7:0]];

  always @(negedge clk)
  begin
    if (o_d_we === 1'b1)
    begin
      log_addr.push_back(o_d_addr);
      log_val.push_back(o_d_wdata);
      dmem[o_d_addr[7:0]] = o_d_wdata;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (limit != 0 && cycles > limit)
    begin
      $display("Timeout: the run went past %0d cycles without finishing.", limit);
      $display("Checks failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // instruction encoders for the three-register, register-imm8 and register-register-imm4 forms.
  function automatic word_t enc_rrr(input opcode_t op, input int r1, input int r2, input int r3);
    return {op, 3'(r1), 1'b0, 3'(r2), 1'b0, 3'(r3)};
  endfunction

  function automatic word_t enc_ri(input opcode_t op, input int r1, input int imm8);
    return {op, 3'(r1), 8'(imm8)};
  endfunction

  function automatic word_t enc_rri(input opcode_t op, input int r1, input int r2, input int imm4);
    return {op, 3'(r1), 1'b0, 3'(r2), 4'(imm4)};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error: test %s, %s: expected %0h, actual %0h", cur_name, what,
               expected, actual);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic emit(input word_t w);
    prog[cur][plen[cur]] = w;
    plen[cur]++;
  endtask

  task automatic expect_store(input word_t a, input word_t v);
    exp_a[cur][exp_n[cur]] = a;
    exp_v[cur][exp_n[cur]] = v;
    exp_n[cur]++;
  endtask

  task automatic start_test(input string name);
    names[cur] = name;
    plen[cur]  = 0;
    exp_n[cur] = 0;
    pre[cur][0] = '0;                           // r0 is loaded from word 0.
    for (int i = 1; i < 16; i++)
    begin
      seed = xorshift(seed);
      pre[cur][i] = seed[15:0];
    end
  endtask

  task automatic halt_pads();
    emit(enc_ri(OP_HALT, 0, 0));
    repeat (3) emit(enc_ri(OP_NOP, 0, 0));      // frozen behind halt.
  endtask

  task automatic build_alu_chain();
    word_t r [8];
    start_test("alu_chain");
    emit(enc_rri(OP_LOAD, 0, 0, 0));
    emit(enc_rri(OP_LOAD, 1, 0, 1));
    emit(enc_rri(OP_LOAD, 2, 0, 2));
    r[1] = pre[cur][1];
    r[2] = pre[cur][2];
    emit(enc_rrr(OP_ADD, 3, 1, 2));             // load-use on r2.
    r[3] = r[1] + r[2];
    emit(enc_rrr(OP_SUB, 4, 3, 1));
    r[4] = r[3] - r[1];
    emit(enc_rrr(OP_AND, 5, 4, 2));
    r[5] = r[4] & r[2];
    emit(enc_rrr(OP_OR, 6, 5, 3));
    r[6] = r[5] | r[3];
    emit(enc_rrr(OP_XOR, 7, 6, 4));
    r[7] = r[6] ^ r[4];
    emit(enc_ri(OP_ADDI, 7, 8'h5a));
    r[7] = r[7] + 16'h005a;
    emit(enc_ri(OP_SUBI, 6, 8'h33));
    r[6] = r[6] - 16'h0033;
    emit(enc_ri(OP_LDIH, 5, 8'ha5));
    r[5] = r[5] + 16'ha500;
    emit(enc_rri(OP_SLL, 1, 7, 3));
    r[1] = r[7] << 3;
    emit(enc_rri(OP_SRL, 2, 6, 5));
    r[2] = r[6] >> 5;
    emit(enc_rri(OP_SRA, 3, 5, 7));
    r[3] = (r[5] >> 7) | (r[5][15] ? 16'hfe00 : 16'h0000);  // sign fills the top seven bits.
    emit(enc_rri(OP_SLA, 4, 1, 2));
    r[4] = r[1] << 2;
    for (int i = 1; i < 8; i++)
    begin
      emit(enc_rri(OP_STORE, i, 0, 7 + i));
      expect_store(word_t'(7 + i), r[i]);
    end
    halt_pads();
    emit(enc_rri(OP_STORE, 1, 0, 15));          // never reaches memory.
  endtask

  task automatic build_load_use();
    word_t r1, r2, r3, r4;
    start_test("load_use");
    emit(enc_rri(OP_LOAD, 0, 0, 0));
    emit(enc_rri(OP_LOAD, 1, 0, 3));
    emit(enc_ri(OP_ADDI, 1, 7));                // uses the load at once.
    r1 = pre[cur][3] + 16'd7;
    emit(enc_rri(OP_STORE, 1, 0, 9));
    expect_store(16'd9, r1);
    emit(enc_rri(OP_LOAD, 2, 0, 4));
    r2 = pre[cur][4];
    emit(enc_rrr(OP_ADD, 3, 2, 1));
    r3 = r2 + r1;
    emit(enc_ri(OP_NOP, 0, 0));
    emit(enc_rri(OP_STORE, 3, 0, 10));          // two back.
    expect_store(16'd10, r3);
    emit(enc_rrr(OP_XOR, 4, 3, 2));
    r4 = r3 ^ r2;
    emit(enc_ri(OP_NOP, 0, 0));
    emit(enc_ri(OP_NOP, 0, 0));
    emit(enc_rri(OP_STORE, 4, 0, 11));          // three back.
    expect_store(16'd11, r4);
    emit(enc_rri(OP_LOAD, 5, 0, 1));
    emit(enc_rri(OP_STORE, 5, 0, 12));
    expect_store(16'd12, pre[cur][1]);
    halt_pads();
  endtask

  // cmp and a branch to pc+5 with three delay slots, then a store that runs only when not taken.
  task automatic branch_block(input opcode_t op, input int ra, input int rb,
                              input word_t va, input word_t vb, input word_t d1,
                              input word_t d2);
    word_t diff;
    logic  taken;
    diff = va - vb;
    emit(enc_rrr(OP_CMP, 0, ra, rb));
    case (op)
      OP_BZ:   taken = (diff == 0);
      OP_BNZ:  taken = (diff != 0);
      OP_BN:   taken = diff[15];
      OP_BNN:  taken = !diff[15];
      default: taken = 1'b1;                    // jump and jmpr.
    endcase
    emit(enc_ri(op, 0, plen[cur] + 5));         // target is absolute since r0 is zero.
    emit(enc_rri(OP_STORE, 1, 0, 8));
    expect_store(16'd8, d1);
    emit(enc_ri(OP_NOP, 0, 0));
    emit(enc_ri(OP_NOP, 0, 0));
    emit(enc_rri(OP_STORE, 2, 0, 9));
    if (!taken)
      expect_store(16'd9, d2);
  endtask

  task automatic build_branches();
    word_t d1, d2, r6;
    start_test("branches");
    d1 = pre[cur][1];
    d2 = pre[cur][2];
    r6 = 16'h8000;                              // 0 plus 0x80 in the upper byte.
    emit(enc_rri(OP_LOAD, 0, 0, 0));
    emit(enc_rri(OP_LOAD, 1, 0, 1));
    emit(enc_rri(OP_LOAD, 2, 0, 2));
    emit(enc_rri(OP_LOAD, 6, 0, 0));
    emit(enc_ri(OP_LDIH, 6, 8'h80));
    branch_block(OP_BZ, 1, 1, d1, d1, d1, d2);
    branch_block(OP_BNZ, 1, 1, d1, d1, d1, d2);
    branch_block(OP_BN, 1, 1, d1, d1, d1, d2);
    branch_block(OP_BNN, 1, 1, d1, d1, d1, d2);
    branch_block(OP_BN, 6, 0, r6, 16'd0, d1, d2);
    branch_block(OP_BNN, 6, 0, r6, 16'd0, d1, d2);
    branch_block(OP_BZ, 6, 0, r6, 16'd0, d1, d2);
    branch_block(OP_BNZ, 6, 0, r6, 16'd0, d1, d2);
    branch_block(OP_JUMP, 1, 2, d1, d2, d1, d2);
    branch_block(OP_JMPR, 1, 2, d1, d2, d1, d2);
    halt_pads();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;                                         // drive and sample after the edge.
  endtask

  task automatic load_memories(input int t);
    for (int i = 0; i < 256; i++)
    begin
      imem[i] = (i < plen[t]) ? prog[t][i] : '0;
      dmem[i] = (i < 16) ? pre[t][i] : '0;
    end
    log_addr.delete();
    log_val.delete();
  endtask

  task automatic reset_dut(input logic enable);
    i_reset  = 1'b1;
    i_start  = 1'b0;
    i_enable = enable;
    repeat (10) next_cycle();
    i_reset = 1'b0;
  endtask

  task automatic run_test(input int t);
    cur_name = names[t];
    load_memories(t);
    reset_dut(1'b1);
    i_start = 1'b1;
    next_cycle();
    i_start = 1'b0;
    check_value("running after start", 1, o_running);
    while (o_running)
      next_cycle();                             // runs until halt stops the pipeline.
    repeat (6) next_cycle();
    check_value("store count", exp_n[t], log_addr.size());
    for (int i = 0; i < exp_n[t]; i++)
    begin
      check_value($sformatf("store %0d address", i), exp_a[t][i], log_addr[i]);
      check_value($sformatf("store %0d data", i), exp_v[t][i], log_val[i]);
    end
  endtask

  // nothing may move without both power enable and a start pulse.
  task automatic idle_checks();
    cur_name = "idle";
    load_memories(0);
    reset_dut(1'b0);
    for (int pass = 0; pass < 2; pass++)
    begin
      i_enable = (pass == 1);
      i_start  = (pass == 0);                   // start without power first.
      repeat (20)
      begin
        next_cycle();
        check_value("running", 0, o_running);
        check_value("instruction address", 0, o_instr_addr);
      end
      i_start = 1'b0;
    end
    check_value("store count", 0, log_addr.size());
  endtask

  task automatic enable_drop();
    cur_name = "enable_drop";
    load_memories(0);
    reset_dut(1'b1);
    i_start = 1'b1;
    next_cycle();
    i_start = 1'b0;
    while (log_addr.size() == 0)
      next_cycle();
    i_enable = 1'b0;                            // second store of the chain is in memory now.
    next_cycle();
    check_value("running after power loss", 0, o_running);
    check_value("stores before power loss", 2, log_addr.size());
    repeat (20) next_cycle();
    check_value("store count after power loss", 2, log_addr.size());
  endtask

  initial
  begin
    int total;
    i_reset  = 1'b1;
    i_start  = 1'b0;
    i_enable = 1'b0;
    cur = 0;
    build_alu_chain();
    cur = 1;
    build_load_use();
    cur = 2;
    build_branches();
    total = 0;
    for (int t = 0; t < NT; t++)
      total += plen[t];
    limit = total * 4 + 100;
    idle_checks();
    for (int t = 0; t < NT; t++)
      run_test(t);
    enable_drop();
    $display("All checks passed");
    $finish;
  end

endmodule

//--- mips16.f
+incdir+source
source/mips16_pkg.sv
source/mips16_run_ctrl.sv
source/mips16_fetch.sv
source/mips16_decode.sv
source/mips16_alu.sv
source/mips16_execute.sv
source/mips16_memory.sv
source/mips16_top.sv
verif/mips16_tb.sv

//--- Bender.yml
package:
  name: mips16

sources:
  - include_dirs:
      - source
    files:
      - source/mips16_pkg.sv
      - source/mips16_run_ctrl.sv
      - source/mips16_fetch.sv
      - source/mips16_decode.sv
      - source/mips16_alu.sv
      - source/mips16_execute.sv
      - source/mips16_memory.sv
      - source/mips16_top.sv
  - target: test
    files:
      - verif/mips16_tb.sv
